/* logic/hazardPkg.sv */
package hazardPkg;

    // issue group width, also the number of E and M stage slots
    localparam int numSlots = 4;

    localparam int regIdxW = 5;

    // two store ports per group
    localparam int maxStoresPerGroup = 2;

    typedef logic [regIdxW-1:0] regIdxT;

    // bit 0 is the oldest slot
    typedef logic [numSlots-1:0] slotMaskT;

    // slots 1 to 3 only, slot 0 has no older slot in the group
    typedef logic [numSlots-2:0] laterMaskT;

    // r0 is hard-wired and never carries a dependence
    localparam regIdxT zeroReg = '0;

    // source operand hit against a producer index
    function automatic logic srcMatch(regIdxT producer, regIdxT src);
        return (producer == src) && (src != zeroReg);
    endfunction

endpackage

/* logic/hazardIf.sv */
`timescale 1ns/1ns

// the four instructions of the current issue group
interface issueGroupIf;

    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rs;
    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rt;
    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] writeReg;

    hazardPkg::slotMaskT regWrite;
    // store
    hazardPkg::slotMaskT memWrite;
    // load
    hazardPkg::slotMaskT memToReg;

    hazardPkg::slotMaskT branch;
    hazardPkg::slotMaskT jr;

    // operand and memory view for the hazard checks
    modport check
    (
        input rs,
        input rt,
        input writeReg,
        input regWrite,
        input memWrite,
        input memToReg
    );

    // control flow view, only the merge stage tests these
    modport combine
    (
        input branch,
        input jr
    );

endinterface

// producers sitting in the E and M stages, one entry per slot
interface pipeStateIf;

    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rtE;
    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] writeRegE;
    hazardPkg::slotMaskT regWriteE;
    hazardPkg::slotMaskT memToRegE;

    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] writeRegM;
    hazardPkg::slotMaskT memToRegM;

    modport check
    (
        input rtE,
        input writeRegE,
        input regWriteE,
        input memToRegE,
        input writeRegM,
        input memToRegM
    );

endinterface

/* logic/groupHazardCheck.sv */
`timescale 1ns/1ns

module groupHazardCheck
(
    issueGroupIf.check grp,
    output hazardPkg::laterMaskT groupRaw,
    output hazardPkg::laterMaskT groupStall
);

    // slot 0 is never held by the group itself, so start at slot 1
    for (genvar i = 1; i < hazardPkg::numSlots; i++)
    begin : gSlot
        logic rawHit;
        logic orderHit;
        logic portHit;
        int unsigned olderStores;

        // ********************
        // register dependence
        // ********************
        always_comb
        begin
            rawHit = 1'b0;
            for (int j = 0; j < i; j++)
            begin
                rawHit |= grp.regWrite[j]
                          & (hazardPkg::srcMatch(grp.writeReg[j], grp.rs[i])
                             | hazardPkg::srcMatch(grp.writeReg[j], grp.rt[i]));
            end
        end

        // ********************
        // load/store ordering
        // ********************
        // older load before a store, or older store before a load
        always_comb
        begin
            orderHit = 1'b0;
            for (int j = 0; j < i; j++)
            begin
                orderHit |= (grp.memToReg[j] & grp.memWrite[i])
                            | (grp.memWrite[j] & grp.memToReg[i]);
            end
        end

        // ********************
        // store port limit
        // ********************
        always_comb
        begin
            olderStores = 0;
            for (int j = 0; j < i; j++)
            begin
                olderStores += 32'(grp.memWrite[j]);
            end
        end

        // both ports already taken by older stores
        assign portHit = grp.memWrite[i]
                         && (olderStores >= hazardPkg::maxStoresPerGroup);

        assign groupRaw[i-1] = rawHit;

        // a store only reads its operands later, so a RAW alone does not hold it
        assign groupStall[i-1] = (rawHit & ~grp.memWrite[i]) | orderHit | portHit;
    end

endmodule

/* logic/pipeHazardCheck.sv */
`timescale 1ns/1ns

module pipeHazardCheck
(
    issueGroupIf.check grp,
    pipeStateIf.check pipe,
    output hazardPkg::slotMaskT loadUseStall,
    output hazardPkg::slotMaskT branchPipeHazard
);

    for (genvar i = 0; i < hazardPkg::numSlots; i++)
    begin : gSlot
        logic loadHit;
        logic eHit;
        logic mHit;

        // ********************
        // load-use
        // ********************
        // a load in any E slot whose rt feeds this slot
        always_comb
        begin
            loadHit = 1'b0;
            for (int k = 0; k < hazardPkg::numSlots; k++)
            begin
                loadHit |= pipe.memToRegE[k]
                           & (hazardPkg::srcMatch(pipe.rtE[k], grp.rs[i])
                              | hazardPkg::srcMatch(pipe.rtE[k], grp.rt[i]));
            end
        end

        // store data goes through forwarding, no stall for a store consumer
        assign loadUseStall[i] = loadHit & ~grp.memWrite[i];

        // ********************
        // branch operands
        // ********************
        // branches resolve early, so any E-stage write is too late
        always_comb
        begin
            eHit = 1'b0;
            mHit = 1'b0;
            for (int k = 0; k < hazardPkg::numSlots; k++)
            begin
                eHit |= pipe.regWriteE[k]
                        & (hazardPkg::srcMatch(pipe.writeRegE[k], grp.rs[i])
                           | hazardPkg::srcMatch(pipe.writeRegE[k], grp.rt[i]));
                // load data in M is not ready yet either
                mHit |= pipe.memToRegM[k]
                        & (hazardPkg::srcMatch(pipe.writeRegM[k], grp.rs[i])
                           | hazardPkg::srcMatch(pipe.writeRegM[k], grp.rt[i]));
            end
        end

        // qualified by branch or jr in stallCombine
        assign branchPipeHazard[i] = eHit | mHit;
    end

endmodule

/* logic/stallCombine.sv */
`timescale 1ns/1ns

module stallCombine
(
    input  logic                 clk,
    input  logic                 rstN,
    issueGroupIf.combine         grp,
    input  hazardPkg::laterMaskT groupRaw,
    input  hazardPkg::laterMaskT groupStall,
    input  hazardPkg::slotMaskT  loadUseStall,
    input  hazardPkg::slotMaskT  branchPipeHazard,
    output hazardPkg::laterMaskT groupStallQ,
    output hazardPkg::slotMaskT  loadUseStallQ,
    output hazardPkg::slotMaskT  branchStallQ,
    output hazardPkg::slotMaskT  issueHoldQ
);

    hazardPkg::slotMaskT rawFull;
    hazardPkg::slotMaskT groupFull;
    hazardPkg::slotMaskT branchStall;
    hazardPkg::slotMaskT stallCause;
    hazardPkg::slotMaskT issueHold;

    // align the in-group masks to slot numbering, slot 0 has none
    assign rawFull   = {groupRaw, 1'b0};
    assign groupFull = {groupStall, 1'b0};

    // ********************
    // branch stall
    // ********************
    always_comb
    begin
        for (int i = 0; i < hazardPkg::numSlots; i++)
        begin
            branchStall[i] = (grp.branch[i] | grp.jr[i])
                             & (branchPipeHazard[i] | rawFull[i]);
        end
    end

    // ********************
    // in-order issue hold
    // ********************
    assign stallCause = groupFull | loadUseStall | branchStall;

    // once a slot waits, every younger slot waits with it
    always_comb
    begin
        logic acc;
        acc = 1'b0;
        for (int i = 0; i < hazardPkg::numSlots; i++)
        begin
            acc |= stallCause[i];
            issueHold[i] = acc;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            groupStallQ   <= '0;
            loadUseStallQ <= '0;
            branchStallQ  <= '0;
            issueHoldQ    <= '0;
        end
        else
        begin
            groupStallQ   <= groupStall;
            loadUseStallQ <= loadUseStall;
            branchStallQ  <= branchStall;
            issueHoldQ    <= issueHold;
        end
    end

    // hold is a prefix, a set bit implies all younger bits set
    holdMonotonic: assert property (@(posedge clk) disable iff (!rstN)
        (hazardPkg::slotMaskT'(issueHoldQ << 1) & ~issueHoldQ) == '0);

    resetClears: assert property (@(posedge clk) $fell(rstN) |=>
        (groupStallQ == '0) && (loadUseStallQ == '0)
        && (branchStallQ == '0) && (issueHoldQ == '0));

    // a slot that issues carries no group or load-use stall
    issueMeansClear: assert property (@(posedge clk) disable iff (!rstN)
        ((hazardPkg::slotMaskT'({groupStallQ, 1'b0}) | loadUseStallQ) & ~issueHoldQ) == '0);

endmodule

/* logic/issueStallUnit.sv */
`timescale 1ns/1ns

module issueStallUnit
(
    input  logic                                        clk,
    input  logic                                        rstN,

    // issue group
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rsI,
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rtI,
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] writeRegI,
    input  hazardPkg::slotMaskT                         regWriteI,
    input  hazardPkg::slotMaskT                         memWriteI,
    input  hazardPkg::slotMaskT                         memToRegI,
    input  hazardPkg::slotMaskT                         branchI,
    input  hazardPkg::slotMaskT                         jrI,

    // E stage producers
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rtE,
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] writeRegE,
    input  hazardPkg::slotMaskT                         regWriteE,
    input  hazardPkg::slotMaskT                         memToRegE,

    // M stage producers
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] writeRegM,
    input  hazardPkg::slotMaskT                         memToRegM,

    output hazardPkg::laterMaskT                        groupStall,
    output hazardPkg::slotMaskT                         loadUseStall,
    output hazardPkg::slotMaskT                         branchStall,
    output hazardPkg::slotMaskT                         issueHold
);

    issueGroupIf grpBus();
    pipeStateIf  pipeBus();

    hazardPkg::laterMaskT groupRaw;
    hazardPkg::laterMaskT groupStallNow;
    hazardPkg::slotMaskT  loadUseNow;
    hazardPkg::slotMaskT  branchPipeHazard;

    assign grpBus.rs       = rsI;
    assign grpBus.rt       = rtI;
    assign grpBus.writeReg = writeRegI;
    assign grpBus.regWrite = regWriteI;
    assign grpBus.memWrite = memWriteI;
    assign grpBus.memToReg = memToRegI;
    assign grpBus.branch   = branchI;
    assign grpBus.jr       = jrI;

    assign pipeBus.rtE       = rtE;
    assign pipeBus.writeRegE = writeRegE;
    assign pipeBus.regWriteE = regWriteE;
    assign pipeBus.memToRegE = memToRegE;
    assign pipeBus.writeRegM = writeRegM;
    assign pipeBus.memToRegM = memToRegM;

    groupHazardCheck u_groupHazardCheck
    (
        .grp        (grpBus.check),
        .groupRaw   (groupRaw),
        .groupStall (groupStallNow)
    );

    pipeHazardCheck u_pipeHazardCheck
    (
        .grp              (grpBus.check),
        .pipe             (pipeBus.check),
        .loadUseStall     (loadUseNow),
        .branchPipeHazard (branchPipeHazard)
    );

    // registered boundary, outputs lag the inputs by one cycle
    stallCombine u_stallCombine
    (
        .clk              (clk),
        .rstN             (rstN),
        .grp              (grpBus.combine),
        .groupRaw         (groupRaw),
        .groupStall       (groupStallNow),
        .loadUseStall     (loadUseNow),
        .branchPipeHazard (branchPipeHazard),
        .groupStallQ      (groupStall),
        .loadUseStallQ    (loadUseStall),
        .branchStallQ     (branchStall),
        .issueHoldQ       (issueHold)
    );

endmodule

/* testbench/stallChecker.sv */
`timescale 1ns/1ns

module stallChecker
(
    input  logic clk,
    input  logic rstN,
    input  int   testNum,
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rsI, rtI, writeRegI,
    input  hazardPkg::slotMaskT regWriteI, memWriteI, memToRegI, branchI, jrI,
    input  hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rtE, writeRegE, writeRegM,
    input  hazardPkg::slotMaskT regWriteE, memToRegE, memToRegM,
    input  hazardPkg::laterMaskT groupStall,
    input  hazardPkg::slotMaskT loadUseStall, branchStall, issueHold,
    output int totalChecks,
    output int totalErrors
);

    int checks = 0;
    int errors = 0;
    int checksAtStart = 0;
    int errorsAtStart = 0;
    // {groupStall, loadUseStall, branchStall, issueHold} one cycle late
    logic [14:0] expQ = '0;

    assign totalChecks = checks;
    assign totalErrors = errors;

    function automatic string testLabel(int n);
        case (n)
            1: return "reset";
            2: return "groupDeps";
            3: return "loadUse";
            4: return "branchOperands";
            5: return "random";
            default: return "idle";
        endcase
    endfunction

    function automatic logic srcHit(hazardPkg::regIdxT producer, hazardPkg::regIdxT src);
        return (src != hazardPkg::zeroReg) && (src == producer);
    endfunction

    // ********************
    // reference model
    // ********************
    function automatic logic [14:0] expectStall();
        logic [2:0] gs;
        logic [3:0] lu;
        logic [3:0] br;
        logic [3:0] hold;
        logic raw;
        logic grpHit;
        logic loadHit;
        logic pipeHit;
        logic held;
        int stores;
        gs = '0;
        held = 1'b0;
        for (int i = 0; i < hazardPkg::numSlots; i++)
        begin
            raw = 1'b0;
            grpHit = 1'b0;
            loadHit = 1'b0;
            pipeHit = 1'b0;
            stores = 0;
            for (int j = 0; j < i; j++)
            begin
                if (regWriteI[j]
                    && (srcHit(writeRegI[j], rsI[i]) || srcHit(writeRegI[j], rtI[i])))
                    raw = 1'b1;
                if ((memToRegI[j] && memWriteI[i]) || (memWriteI[j] && memToRegI[i]))
                    grpHit = 1'b1;
                if (memWriteI[j])
                    stores++;
            end
            if ((raw && !memWriteI[i])
                || (memWriteI[i] && stores >= hazardPkg::maxStoresPerGroup))
                grpHit = 1'b1;
            for (int k = 0; k < hazardPkg::numSlots; k++)
            begin
                if (memToRegE[k] && (srcHit(rtE[k], rsI[i]) || srcHit(rtE[k], rtI[i])))
                    loadHit = 1'b1;
                if (regWriteE[k]
                    && (srcHit(writeRegE[k], rsI[i]) || srcHit(writeRegE[k], rtI[i])))
                    pipeHit = 1'b1;
                if (memToRegM[k]
                    && (srcHit(writeRegM[k], rsI[i]) || srcHit(writeRegM[k], rtI[i])))
                    pipeHit = 1'b1;
            end
            if (i > 0)
                gs[i-1] = grpHit;
            lu[i] = loadHit && !memWriteI[i];
            br[i] = (branchI[i] || jrI[i]) && (pipeHit || raw);
            held = held || grpHit || lu[i] || br[i];
            hold[i] = held;
        end
        return {gs, lu, br, hold};
    endfunction

    // one-cycle delay, matching the registered outputs
    always @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            expQ <= '0;
        else
            expQ <= expectStall();
    end

    task automatic compareField(string field, logic [3:0] expected, logic [3:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH test %s %s: expected %b actual %b",
                     testLabel(testNum), field, expected, actual);
        end
    endtask

    // ********************
    // compare
    // ********************
    always @(negedge clk)
    begin
        logic [3:0] prefixMiss;
        compareField("groupStall", {1'b0, expQ[14:12]}, {1'b0, groupStall});
        compareField("loadUseStall", expQ[11:8], loadUseStall);
        compareField("branchStall", expQ[7:4], branchStall);
        compareField("issueHold", expQ[3:0], issueHold);
        prefixMiss = 4'(issueHold << 1) & ~issueHold;
        if (prefixMiss != '0)
        begin
            errors++;
            $display("test %s: issueHold %b lets a younger slot issue past a held one",
                     testLabel(testNum), issueHold);
        end
    end

    // a new test number closes the previous test
    always @(testNum)
    begin
        if (testNum > 1)
            $display("test %0d %s done: %0d checks, %0d errors", testNum - 1,
                     testLabel(testNum - 1), checks - checksAtStart, errors - errorsAtStart);
        checksAtStart = checks;
        errorsAtStart = errors;
    end

endmodule

/* testbench/tbIssueStall.sv */
`timescale 1ns/1ns

module tbIssueStall;

    localparam int resetCycles = 10;
    // tests 1 to 5, each with 4 cycles to drain
    localparam int cycleLimit = resetCycles + (4 + 8 + 37 + 10 + 2004) + 50;

    logic clk;
    logic rstN;
    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rsI, rtI, writeRegI;
    hazardPkg::slotMaskT regWriteI, memWriteI, memToRegI, branchI, jrI;
    hazardPkg::regIdxT [hazardPkg::numSlots-1:0] rtE, writeRegE, writeRegM;
    hazardPkg::slotMaskT regWriteE, memToRegE, memToRegM;
    hazardPkg::laterMaskT groupStall;
    hazardPkg::slotMaskT loadUseStall, branchStall, issueHold;
    int testNum;
    int totalChecks;
    int totalErrors;
    int cycles = 0;
    integer seed = 32'h40d7_a19a;

    issueStallUnit u_issueStallUnit (.*);
    stallChecker u_stallChecker (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic clearInputs();
        rsI <= '0;
        rtI <= '0;
        writeRegI <= '0;
        regWriteI <= '0;
        memWriteI <= '0;
        memToRegI <= '0;
        branchI <= '0;
        jrI <= '0;
        rtE <= '0;
        writeRegE <= '0;
        writeRegM <= '0;
        regWriteE <= '0;
        memToRegE <= '0;
        memToRegM <= '0;
    endtask

    // each group starts from an idle pipeline
    task automatic nextGroup();
        @(posedge clk);
        clearInputs();
    endtask

    task automatic finishTest();
        nextGroup();
        repeat (2) @(posedge clk);
        testNum++;
        @(posedge clk);
    endtask

    // indices 0 to 7 keep matches frequent
    task automatic randomGroup();
        for (int s = 0; s < hazardPkg::numSlots; s++)
        begin
            rsI[s] <= 5'($random(seed) & 7);
            rtI[s] <= 5'($random(seed) & 7);
            writeRegI[s] <= 5'($random(seed) & 7);
            rtE[s] <= 5'($random(seed) & 7);
            writeRegE[s] <= 5'($random(seed) & 7);
            writeRegM[s] <= 5'($random(seed) & 7);
        end
        regWriteI <= 4'($random(seed));
        memWriteI <= 4'($random(seed));
        memToRegI <= 4'($random(seed));
        branchI <= 4'($random(seed));
        jrI <= 4'($random(seed));
        regWriteE <= 4'($random(seed));
        memToRegE <= 4'($random(seed));
        memToRegM <= 4'($random(seed));
    endtask

    initial
    begin
        testNum = 1;
        rstN <= 1'b0;
        clearInputs();
        // a hazardous group that reset must hide
        memWriteI <= '1;
        branchI <= '1;
        regWriteE <= '1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        clearInputs();
        finishTest();

        // ********************
        // in-group dependences
        // ********************
        nextGroup();
        regWriteI[0] <= 1'b1;
        writeRegI[0] <= 5'd3;
        rsI[2] <= 5'd3;
        nextGroup();
        memToRegI[0] <= 1'b1;
        memWriteI[1] <= 1'b1;
        nextGroup();
        memWriteI <= 4'b0111;
        nextGroup();
        memWriteI <= 4'b1111;
        finishTest();

        // ********************
        // load-use
        // ********************
        for (int e = 0; e < hazardPkg::numSlots; e++)
        begin
            for (int s = 0; s < hazardPkg::numSlots; s++)
            begin
                for (int st = 0; st < 2; st++)
                begin
                    nextGroup();
                    memToRegE[e] <= 1'b1;
                    rtE[e] <= 5'd5;
                    if ((e + s) % 2 == 0)
                        rsI[s] <= 5'd5;
                    else
                        rtI[s] <= 5'd5;
                    // second pass makes the consumer a store
                    memWriteI[s] <= 1'(st);
                end
            end
        end
        // loads into r0 feeding r0 sources
        nextGroup();
        memToRegE <= '1;
        finishTest();

        // ********************
        // branch operands
        // ********************
        for (int ctl = 1; ctl >= 0; ctl--)
        begin
            nextGroup();
            regWriteE[0] <= 1'b1;
            writeRegE[0] <= 5'd6;
            rsI[1] <= 5'd6;
            branchI[1] <= 1'(ctl);
            nextGroup();
            memToRegM[2] <= 1'b1;
            writeRegM[2] <= 5'd7;
            rtI[3] <= 5'd7;
            jrI[3] <= 1'(ctl);
            nextGroup();
            regWriteI[0] <= 1'b1;
            writeRegI[0] <= 5'd2;
            rsI[2] <= 5'd2;
            branchI[2] <= 1'(ctl);
        end
        finishTest();

        repeat (2000)
        begin
            nextGroup();
            randomGroup();
        end
        finishTest();

        $display("all tests done: %0d checks, %0d errors", totalChecks, totalErrors);
        if (totalErrors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        while (cycles < cycleLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timed out after %0d cycles, the tests did not finish", cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* all.f */
logic/hazardPkg.sv
logic/hazardIf.sv
logic/groupHazardCheck.sv
logic/pipeHazardCheck.sv
logic/stallCombine.sv
logic/issueStallUnit.sv
testbench/stallChecker.sv
testbench/tbIssueStall.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tbIssueStall -Mdir obj_dir

out=$(./obj_dir/VtbIssueStall) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1
